//--- Bender.yml
package:
  name: ram_model

sources:
  - files:
      - src/ram_cfg_pkg.sv
      - src/ram_bus_pkg.sv
      - src/ram_req_front.sv
      - src/ram_timing_model.sv
      - src/ram_data_model.sv
      - src/ram_resp_join.sv
      - src/ram_model_top.sv
  - target: test
    files:
      - bench/ram_model_chk.sv
      - bench/ram_model_tb.sv

//--- bench/ram_model_chk.sv
`timescale 1ns/1ps

module ram_model_chk (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dut_rst_n,
    input  logic                    pause,
    input  logic                    req_valid,
    input  logic                    req_ready,
    input  logic                    rsp_valid,
    input  logic                    rsp_ready,
    input  ram_bus_pkg::ram_rsp_t   rsp,
    input  logic                    dut_stall
);

    int unsigned fail_cnt = 0;
    logic        first_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_seen <= 1'b0;
        end else if (req_valid && req_ready) begin
            first_seen <= 1'b1;
        end
    end

    no_accept_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (pause || !dut_rst_n) |-> !req_ready)
        else begin
            $error("req_ready high during pause or DUT reset");
            fail_cnt++;
        end

    rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else begin
            $error("response dropped or changed under back-pressure");
            fail_cnt++;
        end

    // First response needs at least the write delay.
    min_delay: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready && !first_seen) |=> !rsp_valid [*ram_cfg_pkg::w_delay])
        else begin
            $error("response earlier than the minimum delay");
            fail_cnt++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!rsp_valid && !req_ready && !dut_stall))
        else begin
            $error("outputs active in the first cycle after reset");
            fail_cnt++;
        end

    no_stall: assert property (@(posedge clk) disable iff (!rst_n) !dut_stall)
        else begin
            $error("dut_stall raised");
            fail_cnt++;
        end

endmodule

bind ram_model_top ram_model_chk chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .dut_rst_n  (dut_rst_n),
    .pause      (pause),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .dut_stall  (dut_stall)
);

//--- bench/ram_model_tb.sv
`timescale 1ns/1ps

module ram_model_tb;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   dut_rst_n;
    logic                                   pause;
    logic                                   req_valid;
    logic                                   req_ready;
    ram_bus_pkg::ram_req_t                  req;
    logic                                   rsp_valid;
    logic                                   rsp_ready;
    ram_bus_pkg::ram_rsp_t                  rsp;
    logic                                   dut_stall;

    logic [ram_cfg_pkg::data_width-1:0]     ref_mem [ram_cfg_pkg::mem_words];
    bit                                     written [ram_cfg_pkg::mem_words];
    ram_bus_pkg::ram_rsp_t                  exp_q [$];
    logic [ram_cfg_pkg::id_width-1:0]       next_id;
    bit                                     rand_ready;
    int                                     errors;
    int                                     tests_run;
    int                                     tests_failed;

    ram_model_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int err_total();
        return errors + int'(dut.chk.fail_cnt);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // Checks each response against the oldest expected one.
    always @(posedge clk) begin
        ram_bus_pkg::ram_rsp_t exp;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response with id %0d at %0t", rsp.id, $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                compare("rsp.id", rsp.id, exp.id);
                compare("rsp.write", rsp.write, exp.write);
                compare("rsp.rdata", rsp.rdata, exp.rdata);
            end
        end
    end

    always @(negedge clk) begin
        if (rand_ready) begin
            rsp_ready = ($urandom_range(0, 3) != 0);
        end
    end

    task automatic send(input bit wr, input logic [ram_cfg_pkg::addr_width-1:0] addr,
                        input logic [ram_cfg_pkg::data_width-1:0] wdata,
                        input logic [ram_cfg_pkg::strb_width-1:0] wstrb);
        ram_bus_pkg::ram_rsp_t exp;
        int t;
        @(negedge clk);
        req_valid = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = (wr && !written[addr]) ? '1 : wstrb;    // First write fills the word.
        req.id    = next_id;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!req_ready && t < 200);
        if (!req_ready) begin
            $display("Timeout: request id %0d was never accepted", next_id);
            errors++;
        end else begin
            if (wr) begin
                for (int b = 0; b < ram_cfg_pkg::strb_width; b++) begin
                    if (req.wstrb[b]) begin
                        ref_mem[addr][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
                written[addr] = 1'b1;
            end
            exp.id    = next_id;
            exp.write = wr;
            exp.rdata = wr ? '0 : ref_mem[addr];
            exp_q.push_back(exp);
            next_id++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d responses never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int base);
        tests_run++;
        if (err_total() != base) begin
            tests_failed++;
        end
        $display("test %-12s %s", name, (err_total() == base) ? "ok" : "failed");
    endtask

    initial begin
        logic [ram_cfg_pkg::addr_width-1:0] a [8];
        int base;
        int n;
        void'($urandom(32'h6f29));
        rst_n      = 1'b0;
        dut_rst_n  = 1'b1;
        pause      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        rand_ready = 1'b0;
        next_id    = '0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        base = err_total();
        rand_ready = 1'b1;
        foreach (a[i]) begin
            a[i] = ram_cfg_pkg::addr_width'($urandom);
        end
        repeat (2) begin
            foreach (a[i]) begin
                send(1'b1, a[i], $urandom, $urandom_range(1, 15));
            end
        end
        foreach (a[i]) begin
            send(1'b0, a[i], '0, '0);
        end
        rand_ready = 1'b0;
        @(negedge clk) rsp_ready = 1'b1;
        drain();
        finish_test("write_read", base);

        base = err_total();
        send(1'b0, a[0], '0, '0);
        send(1'b1, a[1], $urandom, '1);
        send(1'b0, a[1], '0, '0);
        drain();
        finish_test("ordering", base);

        base = err_total();
        send(1'b0, a[2], '0, '0);
        @(negedge clk) pause = 1'b1;
        n = 15 + $urandom_range(0, 10);
        fork
            send(1'b0, a[3], '0, '0);
            begin
                repeat (n) begin
                    @(posedge clk);
                    assert (!rsp_valid) else begin
                        $display("Response released while paused at %0t", $time);
                        errors++;
                    end
                end
                @(negedge clk) pause = 1'b0;
            end
        join
        drain();
        finish_test("pause", base);

        base = err_total();
        send(1'b0, a[4], '0, '0);
        send(1'b0, a[5], '0, '0);
        @(negedge clk) dut_rst_n = 1'b0;
        n = 10 + $urandom_range(0, 15);
        fork
            send(1'b1, a[6], $urandom, $urandom_range(0, 15));
            begin
                repeat (n) @(posedge clk);
                @(negedge clk) dut_rst_n = 1'b1;
            end
        join
        drain();
        finish_test("dut_reset", base);

        base = err_total();
        @(negedge clk) rsp_ready = 1'b0;
        for (int i = 0; i < ram_cfg_pkg::q_depth; i++) begin
            send(i[0], a[i], $urandom, $urandom_range(0, 15));
        end
        @(negedge clk);
        assert (!req_ready) else begin
            $display("req_ready still high with %0d responses held at %0t",
                     ram_cfg_pkg::q_depth, $time);
            errors++;
        end
        rsp_ready = 1'b1;
        drain();
        finish_test("backpressure", base);

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut.chk.fail_cnt);
        if (tests_failed == 0 && err_total() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src/ram_bus_pkg.sv
package ram_bus_pkg;

    // Request word from the DUT, also carried on both fork branches.
    typedef struct packed {
        logic                                  write;
        logic [ram_cfg_pkg::addr_width-1:0]    addr;
        logic [ram_cfg_pkg::data_width-1:0]    wdata;
        logic [ram_cfg_pkg::strb_width-1:0]    wstrb;
        logic [ram_cfg_pkg::id_width-1:0]      id;
    } ram_req_t;

    typedef struct packed {
        logic [ram_cfg_pkg::id_width-1:0]      id;
        logic [ram_cfg_pkg::data_width-1:0]    rdata;   // Zero for writes.
        logic                                  write;
    } ram_rsp_t;

    // One outstanding request in the timing model.
    typedef struct packed {
        logic [ram_cfg_pkg::id_width-1:0]      id;
        logic [ram_cfg_pkg::cnt_width-1:0]     cnt;     // Cycles left.
    } ram_due_t;

endpackage

//--- src/ram_cfg_pkg.sv
package ram_cfg_pkg;

    localparam int unsigned addr_width = 8;             // Word address.
    localparam int unsigned data_width = 32;
    localparam int unsigned strb_width = data_width / 8;
    localparam int unsigned id_width   = 4;

    localparam int unsigned mem_words  = 256;

    // Response delays in cycles, counted from acceptance.
    localparam int unsigned r_delay    = 12;
    localparam int unsigned w_delay    = 3;

    localparam int unsigned q_depth    = 4;             // Power of two.

    localparam int unsigned cnt_width  = $clog2(r_delay + 1);
    localparam int unsigned ptr_width  = $clog2(q_depth);

endpackage

//--- src/ram_data_model.sv
`timescale 1ns/1ps

module ram_data_model (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    output logic                    req_ready,
    input  ram_bus_pkg::ram_req_t   req,

    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output ram_bus_pkg::ram_rsp_t   rsp
);

    logic [ram_cfg_pkg::data_width-1:0]     mem [ram_cfg_pkg::mem_words];
    ram_bus_pkg::ram_rsp_t                  rsp_q [ram_cfg_pkg::q_depth];
    ram_bus_pkg::ram_rsp_t                  rd_rsp;
    logic [ram_cfg_pkg::ptr_width-1:0]      head;
    logic [ram_cfg_pkg::ptr_width-1:0]      tail;
    logic [ram_cfg_pkg::ptr_width:0]        level;
    logic                                   push;
    logic                                   pop;

    assign push = req_valid && req_ready;
    assign pop  = rsp_valid && rsp_ready;

    assign req_ready = !level[ram_cfg_pkg::ptr_width];
    assign rsp_valid = level != '0;
    assign rsp       = rsp_q[head];

    always_comb begin
        rd_rsp.id    = req.id;
        rd_rsp.write = req.write;
        rd_rsp.rdata = req.write ? '0 : mem[req.addr];     // Read at acceptance.
    end

    always_ff @(posedge clk) begin
        if (push && req.write) begin
            for (int b = 0; b < ram_cfg_pkg::strb_width; b++) begin
                if (req.wstrb[b]) begin
                    mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (push) begin
            rsp_q[tail] <= rd_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            level <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

//--- src/ram_model_top.sv
`timescale 1ns/1ps

module ram_model_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    dut_rst_n,
    input  logic                    pause,

    input  logic                    req_valid,
    output logic                    req_ready,
    input  ram_bus_pkg::ram_req_t   req,

    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output ram_bus_pkg::ram_rsp_t   rsp,

    output logic                    dut_stall
);

    logic                   tm_valid;
    logic                   tm_ready;
    ram_bus_pkg::ram_req_t  tm_req;
    logic                   dm_valid;
    logic                   dm_ready;
    ram_bus_pkg::ram_req_t  dm_req;

    logic                   due_valid;
    logic                   due_ready;
    logic                   data_valid;
    logic                   data_ready;
    ram_bus_pkg::ram_rsp_t  data;

    ram_req_front u_front (
        .clk        (clk),
        .rst_n      (rst_n),
        .dut_rst_n  (dut_rst_n),
        .pause      (pause),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .tm_valid   (tm_valid),
        .tm_ready   (tm_ready),
        .tm_req     (tm_req),
        .dm_valid   (dm_valid),
        .dm_ready   (dm_ready),
        .dm_req     (dm_req)
    );

    ram_timing_model u_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .pause      (pause),
        .req_valid  (tm_valid),
        .req_ready  (tm_ready),
        .req        (tm_req),
        .due_valid  (due_valid),
        .due_ready  (due_ready)
    );

    ram_data_model u_data (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (dm_valid),
        .req_ready  (dm_ready),
        .req        (dm_req),
        .rsp_valid  (data_valid),
        .rsp_ready  (data_ready),
        .rsp        (data)
    );

    ram_resp_join u_join (
        .due_valid  (due_valid),
        .due_ready  (due_ready),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data       (data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .dut_stall  (dut_stall)
    );

endmodule

//--- src/ram_req_front.sv
`timescale 1ns/1ps

module ram_req_front (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    dut_rst_n,
    input  logic                    pause,

    input  logic                    req_valid,
    output logic                    req_ready,
    input  ram_bus_pkg::ram_req_t   req,

    output logic                    tm_valid,
    input  logic                    tm_ready,
    output ram_bus_pkg::ram_req_t   tm_req,

    output logic                    dm_valid,
    input  logic                    dm_ready,
    output ram_bus_pkg::ram_req_t   dm_req
);

    logic stall;
    logic stall_q;
    logic pass;

    assign stall = pause || !dut_rst_n;

    // Held stalled until the first clean cycle after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b1;
        end else begin
            stall_q <= stall;
        end
    end

    assign pass = !stall && !stall_q;

    // Each branch sees valid only when the other can take it too.
    assign req_ready = pass && tm_ready && dm_ready;
    assign tm_valid  = req_valid && pass && dm_ready;
    assign dm_valid  = req_valid && pass && tm_ready;

    assign tm_req = req;
    assign dm_req = req;

endmodule

//--- src/ram_resp_join.sv
`timescale 1ns/1ps

module ram_resp_join (
    input  logic                    due_valid,
    output logic                    due_ready,

    input  logic                    data_valid,
    output logic                    data_ready,
    input  ram_bus_pkg::ram_rsp_t   data,

    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output ram_bus_pkg::ram_rsp_t   rsp,

    output logic                    dut_stall
);

    // Timing decides when, data decides what.
    assign rsp_valid = due_valid && data_valid;
    assign rsp       = data;

    // Both queues pop on the same edge.
    assign due_ready  = rsp_ready && data_valid;
    assign data_ready = rsp_ready && due_valid;

    assign dut_stall = due_valid && !data_valid;         // Due but payload missing.

endmodule

//--- src/ram_timing_model.sv
`timescale 1ns/1ps

module ram_timing_model (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    pause,

    input  logic                    req_valid,
    output logic                    req_ready,
    input  ram_bus_pkg::ram_req_t   req,

    output logic                    due_valid,
    input  logic                    due_ready
);

    ram_bus_pkg::ram_due_t                  due_q [ram_cfg_pkg::q_depth];
    logic [ram_cfg_pkg::ptr_width-1:0]      head;
    logic [ram_cfg_pkg::ptr_width-1:0]      tail;
    logic [ram_cfg_pkg::ptr_width:0]        level;
    logic [ram_cfg_pkg::cnt_width-1:0]      load_cnt;
    logic                                   push;
    logic                                   pop;

    assign push = req_valid && req_ready;
    assign pop  = due_valid && due_ready;

    assign load_cnt = req.write ? ram_cfg_pkg::cnt_width'(ram_cfg_pkg::w_delay)
                                : ram_cfg_pkg::cnt_width'(ram_cfg_pkg::r_delay);

    assign req_ready = !level[ram_cfg_pkg::ptr_width];     // MSB set only when full.

    // Release strictly in order, head first.
    assign due_valid = (level != '0) && (due_q[head].cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            level <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;                        // Wraps at q_depth.
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Counts freeze while paused; a zero count waits for its turn at the head.
    always_ff @(posedge clk) begin
        for (int i = 0; i < ram_cfg_pkg::q_depth; i++) begin
            if (push && tail == ram_cfg_pkg::ptr_width'(i)) begin
                due_q[i].id  <= req.id;
                due_q[i].cnt <= load_cnt;
            end else if (!pause && due_q[i].cnt != '0) begin
                due_q[i].cnt <= due_q[i].cnt - 1'b1;
            end
        end
    end

endmodule

//--- vlog.f
src/ram_cfg_pkg.sv
src/ram_bus_pkg.sv
src/ram_req_front.sv
src/ram_timing_model.sv
src/ram_data_model.sv
src/ram_resp_join.sv
src/ram_model_top.sv
bench/ram_model_chk.sv
bench/ram_model_tb.sv
